// File: dv/issuer_tb_table.svh
`ifndef ISSUER_TB_TABLE_SVH
`define ISSUER_TB_TABLE_SVH

    // name, opcode, rs1, rs2, rd, imm, busy mask, busy cycles | unit, command, imm use
    task automatic fill_table();
        add_row("add", OP_ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0000, 0, UNIT_INT, CMD_ADD, 1'b0);
        add_row("sub", OP_SUB, 5'd4, 5'd5, 5'd6, 32'h0, 4'b0000, 0, UNIT_INT, CMD_SUB, 1'b0);
        add_row("and", OP_AND, 5'd7, 5'd8, 5'd9, 32'h0, 4'b0000, 0, UNIT_INT, CMD_AND, 1'b0);
        add_row("or", OP_OR, 5'd10, 5'd11, 5'd12, 32'h0, 4'b0000, 0, UNIT_INT, CMD_OR, 1'b0);
        add_row("xor", OP_XOR, 5'd13, 5'd14, 5'd15, 32'h0, 4'b0000, 0, UNIT_INT, CMD_XOR, 1'b0);
        add_row("addi", OP_ADDI, 5'd16, 5'd17, 5'd18, 32'h123, 4'b0000, 0, UNIT_INT, CMD_ADD, 1'b1);
        add_random_row("andi_rnd", OP_ANDI, UNIT_INT, CMD_AND, 1'b1);
        add_row("ori", OP_ORI, 5'd19, 5'd0, 5'd20, 32'hffff_f0f0, 4'b0000, 0, UNIT_INT, CMD_OR, 1'b1);
        add_random_row("xori_rnd", OP_XORI, UNIT_INT, CMD_XOR, 1'b1);
        add_row("slt", OP_SLT, 5'd21, 5'd22, 5'd23, 32'h0, 4'b0000, 0, UNIT_CMP, CMD_SLT, 1'b0);
        add_row("sltu", OP_SLTU, 5'd24, 5'd25, 5'd26, 32'h0, 4'b0000, 0, UNIT_CMP, CMD_SLTU, 1'b0);
        add_row("slti", OP_SLTI, 5'd27, 5'd28, 5'd29, 32'hffff_fff0, 4'b0000, 0, UNIT_CMP, CMD_SLT, 1'b1);
        add_random_row("sltiu_rnd", OP_SLTIU, UNIT_CMP, CMD_SLTU, 1'b1);
        add_row("sll", OP_SLL, 5'd30, 5'd31, 5'd1, 32'h0, 4'b0000, 0, UNIT_MD0, CMD_SLL, 1'b0);
        add_row("srl_md1b", OP_SRL, 5'd2, 5'd3, 5'd4, 32'h0, 4'b1000, 0, UNIT_MD0, CMD_SRL, 1'b0);
        add_row("sra_md0b", OP_SRA, 5'd5, 5'd6, 5'd7, 32'h0, 4'b0100, 0, UNIT_MD1, CMD_SRA, 1'b0);
        add_row("slli", OP_SLLI, 5'd8, 5'd9, 5'd10, 32'h5, 4'b0000, 0, UNIT_MD0, CMD_SLL, 1'b1);
        add_random_row("srli_rnd", OP_SRLI, UNIT_MD0, CMD_SRL, 1'b1);
        add_row("srai_md0b", OP_SRAI, 5'd11, 5'd12, 5'd13, 32'h1f, 4'b0100, 0, UNIT_MD1, CMD_SRA, 1'b1);
        add_row("mul", OP_MUL, 5'd14, 5'd15, 5'd16, 32'h0, 4'b0000, 0, UNIT_MD0, CMD_MUL, 1'b0);
        add_random_row("mulh_rnd", OP_MULH, UNIT_MD0, CMD_MULH, 1'b0);
        add_row("mulhu_md0b", OP_MULHU, 5'd17, 5'd18, 5'd19, 32'h0, 4'b0100, 0, UNIT_MD1, CMD_MULHU, 1'b0);
        add_row("mulhsu", OP_MULHSU, 5'd20, 5'd21, 5'd22, 32'h0, 4'b0000, 0, UNIT_MD0, CMD_MULHSU, 1'b0);
        add_row("div_bothb", OP_DIV, 5'd23, 5'd24, 5'd25, 32'h0, 4'b1100, 2, UNIT_MD0, CMD_DIV, 1'b0);
        add_row("divu_md0b", OP_DIVU, 5'd26, 5'd27, 5'd28, 32'h0, 4'b0100, 0, UNIT_MD1, CMD_DIVU, 1'b0);
        add_row("rem", OP_REM, 5'd29, 5'd30, 5'd31, 32'h0, 4'b0000, 0, UNIT_MD0, CMD_REM, 1'b0);
        add_random_row("remu_rnd", OP_REMU, UNIT_MD0, CMD_REMU, 1'b0);
        add_row("add_intb", OP_ADD, 5'd1, 5'd3, 5'd5, 32'h0, 4'b0001, 3, UNIT_INT, CMD_ADD, 1'b0);
        add_row("slt_cmpb", OP_SLT, 5'd2, 5'd4, 5'd6, 32'h0, 4'b0010, 2, UNIT_CMP, CMD_SLT, 1'b0);
        add_row("sub_cmpb", OP_SUB, 5'd3, 5'd5, 5'd7, 32'h0, 4'b0010, 0, UNIT_INT, CMD_SUB, 1'b0);
        add_row("xori_intb", OP_XORI, 5'd9, 5'd1, 5'd2, 32'h55aa, 4'b0001, 1, UNIT_INT, CMD_XOR, 1'b1);
    endtask

`endif

// File: dv/issuer_tb.sv
`timescale 1ns/100ps

module issuer_tb import issue_pkg::*; ();

    localparam int XLEN       = XLEN_DEF;
    localparam int REG_ADDR_W = REG_ADDR_W_DEF;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 i_flush;
    logic [OPCODE_W-1:0]                  i_dec_opcode;
    logic [REG_ADDR_W-1:0]                i_dec_rs1;
    logic [REG_ADDR_W-1:0]                i_dec_rs2;
    logic [REG_ADDR_W-1:0]                i_dec_rd;
    logic [XLEN-1:0]                      i_dec_imm;
    logic                                 i_dec_illegal;
    logic                                 o_dec_busy;
    logic [REG_ADDR_W-1:0]                o_reg_ra0;
    logic [REG_ADDR_W-1:0]                o_reg_ra1;
    logic [XLEN-1:0]                      i_reg_rd0;
    logic [XLEN-1:0]                      i_reg_rd1;
    logic [NUM_UNITS-1:0][XLEN-1:0]       o_alu_arg0;
    logic [NUM_UNITS-1:0][XLEN-1:0]       o_alu_arg1;
    logic [NUM_UNITS-1:0][CMD_W-1:0]      o_alu_cmd;
    logic [NUM_UNITS-1:0][REG_ADDR_W-1:0] o_alu_rd;
    logic [NUM_UNITS-1:0]                 i_alu_busy;
    logic [NUM_UNITS-1:0]                 i_alu_error;
    logic                                 i_halt_pending;
    logic                                 o_halt_needed;

    // Stimulus and expected columns, one entry per table row
    string                 names[$];
    logic [OPCODE_W-1:0]   ops[$];
    logic [REG_ADDR_W-1:0] rs1s[$];
    logic [REG_ADDR_W-1:0] rs2s[$];
    logic [REG_ADDR_W-1:0] rds[$];
    logic [XLEN-1:0]       imms[$];
    logic [NUM_UNITS-1:0]  busy_masks[$];
    int                    busy_cycles[$];
    logic [UNIT_W-1:0]     exp_units[$];
    logic [CMD_W-1:0]      exp_cmds[$];
    bit                    exp_imms[$];

    string  cur_test;
    int     checks;
    int     errors;
    integer seed = 15;

    issuer_top #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) DUT (.*);

    // Register file model, entry a holds a copied into every byte
    function automatic logic [XLEN-1:0] reg_value(input logic [REG_ADDR_W-1:0] a);
        return 32'(a) * 32'h0101_0101;
    endfunction

    assign i_reg_rd0 = reg_value(o_reg_ra0);
    assign i_reg_rd1 = reg_value(o_reg_ra1);

    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        return 5'($random(seed));
    endfunction

    function automatic logic [XLEN-1:0] random_imm();
        return $random(seed);
    endfunction

    task automatic add_row(
        input string                 name,
        input logic [OPCODE_W-1:0]   op,
        input logic [REG_ADDR_W-1:0] rs1,
        input logic [REG_ADDR_W-1:0] rs2,
        input logic [REG_ADDR_W-1:0] rd,
        input logic [XLEN-1:0]       imm,
        input logic [NUM_UNITS-1:0]  busy,
        input int                    cycles,
        input logic [UNIT_W-1:0]     unit,
        input logic [CMD_W-1:0]      cmd,
        input bit                    use_imm
    );
        names.push_back(name);
        ops.push_back(op);
        rs1s.push_back(rs1);
        rs2s.push_back(rs2);
        rds.push_back(rd);
        imms.push_back(imm);
        busy_masks.push_back(busy);
        busy_cycles.push_back(cycles);
        exp_units.push_back(unit);
        exp_cmds.push_back(cmd);
        exp_imms.push_back(use_imm);
    endtask

    // Register and immediate fields drawn from the seeded generator
    task automatic add_random_row(
        input string               name,
        input logic [OPCODE_W-1:0] op,
        input logic [UNIT_W-1:0]   unit,
        input logic [CMD_W-1:0]    cmd,
        input bit                  use_imm
    );
        add_row(name, op, pick_reg(), pick_reg(), pick_reg(), random_imm(),
                4'b0000, 0, unit, cmd, use_imm);
    endtask

`include "issuer_tb_table.svh"

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected 0x%h, actual 0x%h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic expect_unit_idle(input logic [UNIT_W-1:0] u);
        expect_eq($sformatf("unit%0d cmd", u), 32'(CMD_NONE), 32'(o_alu_cmd[u]));
        expect_eq($sformatf("unit%0d arg0", u), 32'h0, o_alu_arg0[u]);
        expect_eq($sformatf("unit%0d arg1", u), 32'h0, o_alu_arg1[u]);
        expect_eq($sformatf("unit%0d rd", u), 32'h0, 32'(o_alu_rd[u]));
    endtask

    task automatic expect_idle();
        for (int u = 0; u < NUM_UNITS; u++) begin
            expect_unit_idle(UNIT_W'(u));
        end
    endtask

    task automatic expect_issue(input int r);
        logic [XLEN-1:0]   exp_arg1;
        logic [UNIT_W-1:0] idx;
        exp_arg1 = exp_imms[r] ? imms[r] : reg_value(rs2s[r]);
        expect_eq("o_dec_busy", 32'd0, 32'(o_dec_busy));
        for (int u = 0; u < NUM_UNITS; u++) begin
            idx = UNIT_W'(u);
            if (idx == exp_units[r]) begin
                expect_eq($sformatf("unit%0d cmd", u), 32'(exp_cmds[r]), 32'(o_alu_cmd[idx]));
                expect_eq($sformatf("unit%0d arg0", u), reg_value(rs1s[r]), o_alu_arg0[idx]);
                expect_eq($sformatf("unit%0d arg1", u), exp_arg1, o_alu_arg1[idx]);
                expect_eq($sformatf("unit%0d rd", u), 32'(rds[r]), 32'(o_alu_rd[idx]));
            end else begin
                expect_unit_idle(idx);
            end
        end
    endtask

    // One row: accept, optional stall, then the single issue cycle
    task automatic apply_row(input int r);
        int k;
        cur_test = names[r];
        @(negedge clk);
        expect_idle();
        i_dec_opcode = ops[r];
        i_dec_rs1    = rs1s[r];
        i_dec_rs2    = rs2s[r];
        i_dec_rd     = rds[r];
        i_dec_imm    = imms[r];
        i_alu_busy   = busy_masks[r];
        @(negedge clk);
        // Read addresses come from the held source fields
        expect_eq("o_reg_ra0", 32'(rs1s[r]), 32'(o_reg_ra0));
        expect_eq("o_reg_ra1", 32'(rs2s[r]), 32'(o_reg_ra1));
        for (k = 0; k < busy_cycles[r]; k++) begin
            expect_eq("o_dec_busy", 32'd1, 32'(o_dec_busy));
            expect_idle();
            i_dec_opcode = OP_NOP;
            if (k == busy_cycles[r] - 1) begin
                i_alu_busy = '0;
            end
            @(negedge clk);
        end
        if (busy_cycles[r] == 0) begin
            expect_eq("o_dec_busy", 32'd0, 32'(o_dec_busy));
            expect_idle();
            i_dec_opcode = OP_NOP;
            @(negedge clk);
        end
        expect_issue(r);
        i_alu_busy = '0;
    endtask

    task automatic flush_stalled();
        cur_test = "flush_stalled";
        @(negedge clk);
        expect_idle();
        i_dec_opcode = OP_XOR;
        i_dec_rs1    = 5'd7;
        i_dec_rs2    = 5'd9;
        i_dec_rd     = 5'd11;
        i_alu_busy   = 4'b0001;
        @(negedge clk);
        expect_eq("o_dec_busy", 32'd1, 32'(o_dec_busy));
        i_dec_opcode = OP_NOP;
        i_flush      = 1'b1;
        @(negedge clk);
        // Held XOR is gone, so busy no longer matters
        expect_eq("o_dec_busy", 32'd0, 32'(o_dec_busy));
        expect_idle();
        i_flush    = 1'b0;
        i_alu_busy = '0;
        repeat (3) begin
            @(negedge clk);
            expect_idle();
        end
        // Flush in the cycle a free instruction would issue
        cur_test     = "flush_issue";
        i_dec_opcode = OP_ADD;
        @(negedge clk);
        expect_eq("o_dec_busy", 32'd0, 32'(o_dec_busy));
        i_dec_opcode = OP_NOP;
        i_flush      = 1'b1;
        @(negedge clk);
        expect_idle();
        i_flush = 1'b0;
        @(negedge clk);
        expect_idle();
    endtask

    task automatic sweep_halt_inputs();
        int   v;
        logic exp_halt;
        cur_test = "halt_sweep";
        for (v = 0; v < 64; v++) begin
            @(negedge clk);
            i_alu_error    = v[3:0];
            i_halt_pending = v[4];
            i_dec_illegal  = v[5];
            #1;
            // Any raised halt source means a nonzero sweep value
            exp_halt = (v != 0);
            expect_eq("o_halt_needed", 32'(exp_halt), 32'(o_halt_needed));
        end
        @(negedge clk);
        i_alu_error    = '0;
        i_halt_pending = 1'b0;
        i_dec_illegal  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #1;
        repeat (names.size() * 12 + 50) begin
            @(posedge clk);
        end
        $display("Watchdog expired after %0d cycles, %0d errors so far",
                 names.size() * 12 + 50, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        fill_table();
        rst_n          = 1'b0;
        i_flush        = 1'b0;
        i_dec_opcode   = OP_NOP;
        i_dec_rs1      = '0;
        i_dec_rs2      = '0;
        i_dec_rd       = '0;
        i_dec_imm      = '0;
        i_dec_illegal  = 1'b0;
        i_alu_busy     = '0;
        i_alu_error    = '0;
        i_halt_pending = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        cur_test = "reset";
        expect_eq("o_dec_busy", 32'd0, 32'(o_dec_busy));
        expect_idle();
        rst_n = 1'b1;

        for (int r = 0; r < names.size(); r++) begin
            apply_row(r);
        end
        flush_stalled();
        sweep_halt_inputs();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/issue_classify.sv
`timescale 1ns/100ps

module issue_classify import issue_pkg::*; (
    input  logic [OPCODE_W-1:0] i_opcode,
    output logic [CLASS_W-1:0]  o_class_req,
    output logic [CMD_W-1:0]    o_cmd,
    output logic                o_use_imm
);

    // Opcode to unit command
    always_comb begin
        case (i_opcode)
            OP_ADD, OP_ADDI:   o_cmd = CMD_ADD;
            OP_SUB:            o_cmd = CMD_SUB;
            OP_AND, OP_ANDI:   o_cmd = CMD_AND;
            OP_OR, OP_ORI:     o_cmd = CMD_OR;
            OP_XOR, OP_XORI:   o_cmd = CMD_XOR;
            OP_SLT, OP_SLTI:   o_cmd = CMD_SLT;
            OP_SLTU, OP_SLTIU: o_cmd = CMD_SLTU;
            OP_SLL, OP_SLLI:   o_cmd = CMD_SLL;
            OP_SRL, OP_SRLI:   o_cmd = CMD_SRL;
            OP_SRA, OP_SRAI:   o_cmd = CMD_SRA;
            OP_MUL:            o_cmd = CMD_MUL;
            OP_MULH:           o_cmd = CMD_MULH;
            OP_MULHU:          o_cmd = CMD_MULHU;
            OP_MULHSU:         o_cmd = CMD_MULHSU;
            OP_DIV:            o_cmd = CMD_DIV;
            OP_DIVU:           o_cmd = CMD_DIVU;
            OP_REM:            o_cmd = CMD_REM;
            OP_REMU:           o_cmd = CMD_REMU;
            // NOP and anything unknown
            default:           o_cmd = CMD_NONE;
        endcase
    end

    // Unit class follows from the command
    always_comb begin
        o_class_req = '0;
        case (o_cmd)
            CMD_ADD, CMD_SUB, CMD_AND, CMD_OR, CMD_XOR: begin
                o_class_req[CLS_INT] = 1'b1;
            end
            CMD_SLT, CMD_SLTU: begin
                o_class_req[CLS_CMP] = 1'b1;
            end
            CMD_SLL, CMD_SRL, CMD_SRA,
            CMD_MUL, CMD_MULH, CMD_MULHU, CMD_MULHSU,
            CMD_DIV, CMD_DIVU, CMD_REM, CMD_REMU: begin
                o_class_req[CLS_MD] = 1'b1;
            end
            default: begin
                o_class_req = '0;
            end
        endcase
    end

    // Immediate forms take arg1 from the immediate
    assign o_use_imm = i_opcode inside {
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLTI, OP_SLTIU,
        OP_SLLI, OP_SRLI, OP_SRAI
    };

    // Immediate list and command table must agree on every opcode
    always_comb begin
        a_imm_has_class : assert (!(o_use_imm && o_class_req == '0))
            else $error("immediate select without a unit class");
    end

endmodule

// File: hdl/issue_dispatch.sv
`timescale 1ns/100ps

module issue_dispatch import issue_pkg::*; #(
    parameter int XLEN       = XLEN_DEF,
    parameter int REG_ADDR_W = REG_ADDR_W_DEF
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_flush,
    input  logic [CLASS_W-1:0]                     i_class_req,
    input  logic [CMD_W-1:0]                       i_cmd,
    input  logic                                   i_use_imm,
    input  logic [REG_ADDR_W-1:0]                  i_rd,
    input  logic [XLEN-1:0]                        i_imm,
    input  logic [XLEN-1:0]                        i_reg_rd0,
    input  logic [XLEN-1:0]                        i_reg_rd1,
    input  logic [NUM_UNITS-1:0]                   i_alu_busy,
    input  logic [NUM_UNITS-1:0]                   i_alu_error,
    input  logic                                   i_halt_pending,
    input  logic                                   i_dec_illegal,
    output logic                                   o_stall,
    output logic [NUM_UNITS-1:0][XLEN-1:0]         o_alu_arg0,
    output logic [NUM_UNITS-1:0][XLEN-1:0]         o_alu_arg1,
    output logic [NUM_UNITS-1:0][CMD_W-1:0]        o_alu_cmd,
    output logic [NUM_UNITS-1:0][REG_ADDR_W-1:0]   o_alu_rd,
    output logic                                   o_halt_needed
);

    logic [UNIT_W-1:0]    unit_sel;
    logic                 do_issue;
    logic [XLEN-1:0]      arg1;
    logic [NUM_UNITS-1:0] cmd_active;

    // Target unit and stall, MD1 only takes over when MD0 is busy
    always_comb begin
        unit_sel = UNIT_INT;
        o_stall  = 1'b0;
        if (i_class_req[CLS_INT]) begin
            unit_sel = UNIT_INT;
            o_stall  = i_alu_busy[UNIT_INT];
        end else if (i_class_req[CLS_CMP]) begin
            unit_sel = UNIT_CMP;
            o_stall  = i_alu_busy[UNIT_CMP];
        end else if (i_class_req[CLS_MD]) begin
            if (!i_alu_busy[UNIT_MD0]) begin
                unit_sel = UNIT_MD0;
            end else begin
                unit_sel = UNIT_MD1;
                o_stall  = i_alu_busy[UNIT_MD1];
            end
        end
    end

    assign do_issue = (|i_class_req) && !o_stall && !i_flush;
    assign arg1     = i_use_imm ? i_imm : i_reg_rd1;

    // Unit ports are a one-cycle pulse, idle slots read as all zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_alu_arg0 <= '0;
            o_alu_arg1 <= '0;
            o_alu_cmd  <= {NUM_UNITS{CMD_NONE}};
            o_alu_rd   <= '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                o_alu_arg0[u] <= '0;
                o_alu_arg1[u] <= '0;
                o_alu_cmd[u]  <= CMD_NONE;
                o_alu_rd[u]   <= '0;
            end
            if (do_issue) begin
                o_alu_arg0[unit_sel] <= i_reg_rd0;
                o_alu_arg1[unit_sel] <= arg1;
                o_alu_cmd[unit_sel]  <= i_cmd;
                o_alu_rd[unit_sel]   <= i_rd;
            end
        end
    end

    // Any unit fault, a bad decode or a pending trap stops the core
    assign o_halt_needed = (|i_alu_error) | i_halt_pending | i_dec_illegal;

    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            cmd_active[u] = (o_alu_cmd[u] != CMD_NONE);
        end
    end

    // One instruction per cycle leaves the issuer
    a_single_issue : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(cmd_active)
    ) else $error("more than one unit command in a cycle");

endmodule

// File: hdl/issue_in_stage.sv
`timescale 1ns/100ps

module issue_in_stage import issue_pkg::*; #(
    parameter int XLEN       = XLEN_DEF,
    parameter int REG_ADDR_W = REG_ADDR_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_flush,
    input  logic                  i_stall,
    input  logic [OPCODE_W-1:0]   i_dec_opcode,
    input  logic [REG_ADDR_W-1:0] i_dec_rs1,
    input  logic [REG_ADDR_W-1:0] i_dec_rs2,
    input  logic [REG_ADDR_W-1:0] i_dec_rd,
    input  logic [XLEN-1:0]       i_dec_imm,
    output logic [OPCODE_W-1:0]   o_opcode,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic [XLEN-1:0]       o_imm,
    output logic [REG_ADDR_W-1:0] o_reg_ra0,
    output logic [REG_ADDR_W-1:0] o_reg_ra1
);

    logic [REG_ADDR_W-1:0] r_rs1;
    logic [REG_ADDR_W-1:0] r_rs2;

    // Held opcode, a NOP marks an empty slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_opcode <= OP_NOP;
        end else if (i_flush) begin
            o_opcode <= OP_NOP;
        end else if (!i_stall) begin
            o_opcode <= i_dec_opcode;
        end
    end

    // Operand fields follow the opcode
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            r_rs1 <= i_dec_rs1;
            r_rs2 <= i_dec_rs2;
            o_rd  <= i_dec_rd;
            o_imm <= i_dec_imm;
        end
    end

    // Register file read port, data comes back in the same cycle
    assign o_reg_ra0 = r_rs1;
    assign o_reg_ra1 = r_rs2;

    // A stalled instruction must wait in place for its unit
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_stall && !i_flush) |=> $stable(o_opcode)
    ) else $error("held opcode changed under stall");

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

    // Default widths, overridden through the top level parameters
    localparam int XLEN_DEF       = 32;
    localparam int REG_ADDR_W_DEF = 5;

    // Decoder opcode codes
    localparam int OPCODE_W = 6;

    localparam logic [OPCODE_W-1:0] OP_NOP    = 6'd0;
    localparam logic [OPCODE_W-1:0] OP_ADD    = 6'd1;
    localparam logic [OPCODE_W-1:0] OP_SUB    = 6'd2;
    localparam logic [OPCODE_W-1:0] OP_AND    = 6'd3;
    localparam logic [OPCODE_W-1:0] OP_OR     = 6'd4;
    localparam logic [OPCODE_W-1:0] OP_XOR    = 6'd5;
    localparam logic [OPCODE_W-1:0] OP_ADDI   = 6'd6;
    localparam logic [OPCODE_W-1:0] OP_ANDI   = 6'd7;
    localparam logic [OPCODE_W-1:0] OP_ORI    = 6'd8;
    localparam logic [OPCODE_W-1:0] OP_XORI   = 6'd9;
    localparam logic [OPCODE_W-1:0] OP_SLT    = 6'd10;
    localparam logic [OPCODE_W-1:0] OP_SLTU   = 6'd11;
    localparam logic [OPCODE_W-1:0] OP_SLTI   = 6'd12;
    localparam logic [OPCODE_W-1:0] OP_SLTIU  = 6'd13;
    localparam logic [OPCODE_W-1:0] OP_SLL    = 6'd14;
    localparam logic [OPCODE_W-1:0] OP_SRL    = 6'd15;
    localparam logic [OPCODE_W-1:0] OP_SRA    = 6'd16;
    localparam logic [OPCODE_W-1:0] OP_SLLI   = 6'd17;
    localparam logic [OPCODE_W-1:0] OP_SRLI   = 6'd18;
    localparam logic [OPCODE_W-1:0] OP_SRAI   = 6'd19;
    localparam logic [OPCODE_W-1:0] OP_MUL    = 6'd20;
    localparam logic [OPCODE_W-1:0] OP_MULH   = 6'd21;
    localparam logic [OPCODE_W-1:0] OP_MULHU  = 6'd22;
    localparam logic [OPCODE_W-1:0] OP_MULHSU = 6'd23;
    localparam logic [OPCODE_W-1:0] OP_DIV    = 6'd24;
    localparam logic [OPCODE_W-1:0] OP_DIVU   = 6'd25;
    localparam logic [OPCODE_W-1:0] OP_REM    = 6'd26;
    localparam logic [OPCODE_W-1:0] OP_REMU   = 6'd27;

    // Unit command codes, shared by register and immediate forms
    localparam int CMD_W = 5;

    localparam logic [CMD_W-1:0] CMD_NONE   = 5'd0;
    localparam logic [CMD_W-1:0] CMD_ADD    = 5'd1;
    localparam logic [CMD_W-1:0] CMD_SUB    = 5'd2;
    localparam logic [CMD_W-1:0] CMD_AND    = 5'd3;
    localparam logic [CMD_W-1:0] CMD_OR     = 5'd4;
    localparam logic [CMD_W-1:0] CMD_XOR    = 5'd5;
    localparam logic [CMD_W-1:0] CMD_SLT    = 5'd6;
    localparam logic [CMD_W-1:0] CMD_SLTU   = 5'd7;
    localparam logic [CMD_W-1:0] CMD_SLL    = 5'd8;
    localparam logic [CMD_W-1:0] CMD_SRL    = 5'd9;
    localparam logic [CMD_W-1:0] CMD_SRA    = 5'd10;
    localparam logic [CMD_W-1:0] CMD_MUL    = 5'd11;
    localparam logic [CMD_W-1:0] CMD_MULH   = 5'd12;
    localparam logic [CMD_W-1:0] CMD_MULHU  = 5'd13;
    localparam logic [CMD_W-1:0] CMD_MULHSU = 5'd14;
    localparam logic [CMD_W-1:0] CMD_DIV    = 5'd15;
    localparam logic [CMD_W-1:0] CMD_DIVU   = 5'd16;
    localparam logic [CMD_W-1:0] CMD_REM    = 5'd17;
    localparam logic [CMD_W-1:0] CMD_REMU   = 5'd18;

    // Execution units and their slot in the per-unit port vectors
    localparam int NUM_UNITS = 4;
    localparam int UNIT_W    = $clog2(NUM_UNITS);

    localparam logic [UNIT_W-1:0] UNIT_INT = 2'd0;
    localparam logic [UNIT_W-1:0] UNIT_CMP = 2'd1;
    localparam logic [UNIT_W-1:0] UNIT_MD0 = 2'd2;
    localparam logic [UNIT_W-1:0] UNIT_MD1 = 2'd3;

    // One-hot class request bits from classify to dispatch
    localparam int CLASS_W = 3;
    localparam int CLS_INT = 0;
    localparam int CLS_CMP = 1;
    localparam int CLS_MD  = 2;

endpackage

// File: hdl/issuer_top.sv
`timescale 1ns/100ps

module issuer_top import issue_pkg::*; #(
    parameter int XLEN       = XLEN_DEF,
    parameter int REG_ADDR_W = REG_ADDR_W_DEF
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 i_flush,

    // Decoder side
    input  logic [OPCODE_W-1:0]                  i_dec_opcode,
    input  logic [REG_ADDR_W-1:0]                i_dec_rs1,
    input  logic [REG_ADDR_W-1:0]                i_dec_rs2,
    input  logic [REG_ADDR_W-1:0]                i_dec_rd,
    input  logic [XLEN-1:0]                      i_dec_imm,
    input  logic                                 i_dec_illegal,
    output logic                                 o_dec_busy,

    // Register file read port
    output logic [REG_ADDR_W-1:0]                o_reg_ra0,
    output logic [REG_ADDR_W-1:0]                o_reg_ra1,
    input  logic [XLEN-1:0]                      i_reg_rd0,
    input  logic [XLEN-1:0]                      i_reg_rd1,

    // Execution units
    output logic [NUM_UNITS-1:0][XLEN-1:0]       o_alu_arg0,
    output logic [NUM_UNITS-1:0][XLEN-1:0]       o_alu_arg1,
    output logic [NUM_UNITS-1:0][CMD_W-1:0]      o_alu_cmd,
    output logic [NUM_UNITS-1:0][REG_ADDR_W-1:0] o_alu_rd,
    input  logic [NUM_UNITS-1:0]                 i_alu_busy,
    input  logic [NUM_UNITS-1:0]                 i_alu_error,

    // Trap handling
    input  logic                                 i_halt_pending,
    output logic                                 o_halt_needed
);

    logic [OPCODE_W-1:0]   held_opcode;
    logic [REG_ADDR_W-1:0] held_rd;
    logic [XLEN-1:0]       held_imm;
    logic [CLASS_W-1:0]    class_req;
    logic [CMD_W-1:0]      unit_cmd;
    logic                  use_imm;
    logic                  stall;

    issue_in_stage #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_in_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_flush      (i_flush),
        .i_stall      (stall),
        .i_dec_opcode (i_dec_opcode),
        .i_dec_rs1    (i_dec_rs1),
        .i_dec_rs2    (i_dec_rs2),
        .i_dec_rd     (i_dec_rd),
        .i_dec_imm    (i_dec_imm),
        .o_opcode     (held_opcode),
        .o_rd         (held_rd),
        .o_imm        (held_imm),
        .o_reg_ra0    (o_reg_ra0),
        .o_reg_ra1    (o_reg_ra1)
    );

    issue_classify u_classify (
        .i_opcode    (held_opcode),
        .o_class_req (class_req),
        .o_cmd       (unit_cmd),
        .o_use_imm   (use_imm)
    );

    issue_dispatch #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_dispatch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_flush        (i_flush),
        .i_class_req    (class_req),
        .i_cmd          (unit_cmd),
        .i_use_imm      (use_imm),
        .i_rd           (held_rd),
        .i_imm          (held_imm),
        .i_reg_rd0      (i_reg_rd0),
        .i_reg_rd1      (i_reg_rd1),
        .i_alu_busy     (i_alu_busy),
        .i_alu_error    (i_alu_error),
        .i_halt_pending (i_halt_pending),
        .i_dec_illegal  (i_dec_illegal),
        .o_stall        (stall),
        .o_alu_arg0     (o_alu_arg0),
        .o_alu_arg1     (o_alu_arg1),
        .o_alu_cmd      (o_alu_cmd),
        .o_alu_rd       (o_alu_rd),
        .o_halt_needed  (o_halt_needed)
    );

    // Decoder holds while the issuer waits on a unit
    assign o_dec_busy = stall;

endmodule

// File: issuer.f
+incdir+dv
hdl/issue_pkg.sv
hdl/issue_in_stage.sv
hdl/issue_classify.sv
hdl/issue_dispatch.sv
hdl/issuer_top.sv
dv/issuer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issuer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f issuer.f --top-module issuer_tb -o issuer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/issuer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
